// File: sim.f
+incdir+include
hw/safe_domain_pkg.sv
hw/pad_regs.sv
hw/pad_control.sv
hw/rst_hold.sv
hw/slow_clk_div.sv
hw/safe_domain.sv
verification/tb_clk_gen.sv
verification/tb_safe_domain.sv

// File: Makefile
# Verilator build and run of the always-on pad domain testbench
BIN := obj_dir/Vtb_safe_domain

.PHONY: all run lint clean

all: run

$(BIN): sim.f hw/*.sv include/*.svh verification/*.sv
	verilator --binary --timing --assert -f sim.f --top-module tb_safe_domain -Mdir obj_dir

run: $(BIN)
	@./$(BIN) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall +incdir+include hw/safe_domain_pkg.sv hw/pad_regs.sv \
	  hw/pad_control.sv hw/rst_hold.sv hw/slow_clk_div.sv hw/safe_domain.sv \
	  --top-module safe_domain

clean:
	rm -rf obj_dir sim.log

// File: verification/tb_safe_domain.sv
//**************************************************************************
// testbench of the always-on pad domain
// applies a table of pad register writes, checks pad routing, read back,
// reset stretching and the slow clock against values worked out here
//**************************************************************************

`include "pad_reg_map.svh"

module tb_safe_domain;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned N_IO     = 16;
  localparam int unsigned SLOW_DIV = 8;
  localparam int unsigned RST_HOLD = 4;
  localparam int unsigned HALF     = SLOW_DIV / 2;
  localparam int unsigned NUM_ROWS = 12;
  // watchdog budget grows with the table
  localparam int unsigned WATCHDOG_CYCLES = NUM_ROWS * 10 + 200;

  typedef logic [N_IO-1:0] vec_t;

  // one table row: pad index, what to write and whether to read it back
  typedef struct packed {
    logic [`PAD_ADDR_W-1:0]     pad;
    safe_domain_pkg::pad_func_e func;
    safe_domain_pkg::pad_cfg_t  cfg;
    logic                       rd_back;
  } row_t;

  logic clk, rst_n, rst_req, chip_rst_n, slow_clk;
  logic wr_stb, rd_stb, rd_valid;
  safe_domain_pkg::pad_cmd_t wr_cmd;
  logic [`PAD_ADDR_W-1:0] rd_addr;
  safe_domain_pkg::pad_reg_t rd_data;
  safe_domain_pkg::pad_cfg_t [N_IO-1:0] pad_cfg;
  vec_t io_out, io_oe, io_in;
  vec_t perio_out, perio_oe, perio_in;
  vec_t apbio_out, apbio_oe, apbio_in;
  vec_t fpgaio_out, fpgaio_oe, fpgaio_in;

  // register contents as the testbench expects them
  safe_domain_pkg::pad_reg_t model [N_IO];
  row_t stim_rows [NUM_ROWS];
  int seed = 32'h4856;
  int err_cnt, test_err_start, pass_cnt, fail_cnt;

  tb_clk_gen i_clk_gen (.rst_req_i(rst_req), .clk_o(clk), .rst_n_o(rst_n));

  safe_domain #(
    .N_IO     (N_IO),
    .SLOW_DIV (SLOW_DIV),
    .RST_HOLD (RST_HOLD)
  ) i_dut (
    .ref_clk_i (clk), .rst_n_i (rst_n), .rst_no (chip_rst_n), .slow_clk_o (slow_clk),
    .wr_stb_i (wr_stb), .wr_cmd_i (wr_cmd), .rd_stb_i (rd_stb), .rd_addr_i (rd_addr),
    .rd_valid_o (rd_valid), .rd_data_o (rd_data), .pad_cfg_o (pad_cfg),
    .io_out_o (io_out), .io_oe_o (io_oe), .io_in_i (io_in),
    .perio_out_i (perio_out), .perio_oe_i (perio_oe), .perio_in_o (perio_in),
    .apbio_out_i (apbio_out), .apbio_oe_i (apbio_oe), .apbio_in_o (apbio_in),
    .fpgaio_out_i (fpgaio_out), .fpgaio_oe_i (fpgaio_oe), .fpgaio_in_o (fpgaio_in)
  );

  //************************************************************************
  // helpers
  //************************************************************************

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic row_t make_row(input logic [7:0] pad,
                                    input safe_domain_pkg::pad_func_e func,
                                    input logic [5:0] cfg, input logic rd_back);
    row_t r;
    r.pad     = pad;
    r.func    = func;
    r.cfg     = safe_domain_pkg::pad_cfg_t'(cfg);
    r.rd_back = rd_back;
    return r;
  endfunction

  task automatic drive_random_groups();
    io_in      = vec_t'($random(seed));
    perio_out  = vec_t'($random(seed));
    perio_oe   = vec_t'($random(seed));
    apbio_out  = vec_t'($random(seed));
    apbio_oe   = vec_t'($random(seed));
    fpgaio_out = vec_t'($random(seed));
    fpgaio_oe  = vec_t'($random(seed));
  endtask

  // the routing rule: the selected group drives the pad and gets its
  // input, every other group sees 0, a switched off pad drives nothing
  task automatic check_pads();
    vec_t exp_out, exp_oe, exp_per, exp_apb, exp_fpga;
    exp_out  = '0;
    exp_oe   = '0;
    exp_per  = '0;
    exp_apb  = '0;
    exp_fpga = '0;
    for (int i = 0; i < N_IO; i++) begin
      case (model[i].func)
        safe_domain_pkg::FUNC_PERIO: begin
          exp_out[i] = perio_out[i];
          exp_oe[i]  = perio_oe[i];
          exp_per[i] = io_in[i];
        end
        safe_domain_pkg::FUNC_APBIO: begin
          exp_out[i] = apbio_out[i];
          exp_oe[i]  = apbio_oe[i];
          exp_apb[i] = io_in[i];
        end
        safe_domain_pkg::FUNC_FPGAIO: begin
          exp_out[i]  = fpgaio_out[i];
          exp_oe[i]   = fpgaio_oe[i];
          exp_fpga[i] = io_in[i];
        end
        default: begin
        end
      endcase
      check_val($sformatf("pad_cfg_o[%0d]", i), 32'(pad_cfg[i]), 32'(model[i].cfg));
    end
    check_val("io_out_o", 32'(io_out), 32'(exp_out));
    check_val("io_oe_o", 32'(io_oe), 32'(exp_oe));
    check_val("perio_in_o", 32'(perio_in), 32'(exp_per));
    check_val("apbio_in_o", 32'(apbio_in), 32'(exp_apb));
    check_val("fpgaio_in_o", 32'(fpgaio_in), 32'(exp_fpga));
  endtask

  // valid must be low in the strobe cycle, high one cycle later and
  // low again after that
  task automatic read_pad(input logic [7:0] addr, input safe_domain_pkg::pad_reg_t exp);
    rd_stb  = 1'b1;
    rd_addr = addr;
    check_val("rd_valid_o", 32'(rd_valid), 32'(0));
    @(posedge clk);
    #1;
    rd_stb = 1'b0;
    check_val("rd_valid_o", 32'(rd_valid), 32'(1));
    check_val($sformatf("rd_data_o[%0d]", addr), 32'(rd_data), 32'(exp));
    @(posedge clk);
    #1;
    check_val("rd_valid_o", 32'(rd_valid), 32'(0));
  endtask

  // edge n counts from the first edge that samples the reset high
  task automatic check_after_release();
    check_val("rst_no", 32'(chip_rst_n), 32'(0));
    check_val("slow_clk_o", 32'(slow_clk), 32'(0));
    for (int n = 1; n <= int'(3 * SLOW_DIV); n++) begin
      @(posedge clk);
      #1;
      check_val("rst_no", 32'(chip_rst_n), 32'(n > int'(RST_HOLD)));
      check_val("slow_clk_o", 32'(slow_clk), 32'((n / int'(HALF)) % 2));
    end
  endtask

  task automatic check_reset_state();
    drive_random_groups();
    @(posedge clk);
    #1;
    check_val("rd_valid_o", 32'(rd_valid), 32'(0));
    check_pads();
    for (int i = 0; i < N_IO; i++) begin
      read_pad(8'(i), safe_domain_pkg::pad_reg_t'(`PAD_REG_RESET));
    end
  endtask

  task automatic apply_row(input row_t row);
    safe_domain_pkg::pad_reg_t exp_rd;
    wr_stb           = 1'b1;
    wr_cmd.addr      = row.pad;
    wr_cmd.data.cfg  = row.cfg;
    wr_cmd.data.func = row.func;
    exp_rd           = safe_domain_pkg::pad_reg_t'(`PAD_REG_RESET);
    // writes beyond the last pad are dropped
    if (32'(row.pad) < N_IO) begin
      model[int'(row.pad)] = wr_cmd.data;
      exp_rd               = wr_cmd.data;
    end
    @(posedge clk);
    #1;
    wr_stb = 1'b0;
    drive_random_groups();
    @(posedge clk);
    #1;
    check_pads();
    if (row.rd_back) begin
      read_pad(row.pad, exp_rd);
    end
  endtask

  task automatic pulse_reset();
    rst_req = 1'b1;
    for (int i = 0; i < N_IO; i++) begin
      model[i] = safe_domain_pkg::pad_reg_t'(`PAD_REG_RESET);
    end
    repeat (3) @(posedge clk);
    #1;
    rst_req = 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err_start) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d mismatches", name, err_cnt - test_err_start);
    end
    test_err_start = err_cnt;
  endtask

  //************************************************************************
  // main sequence
  //************************************************************************

  initial begin
    rst_req = 1'b0;
    wr_stb  = 1'b0;
    wr_cmd  = '0;
    rd_stb  = 1'b0;
    rd_addr = '0;
    io_in   = '0;
    perio_out  = '0;
    perio_oe   = '0;
    apbio_out  = '0;
    apbio_oe   = '0;
    fpgaio_out = '0;
    fpgaio_oe  = '0;
    for (int i = 0; i < N_IO; i++) begin
      model[i] = safe_domain_pkg::pad_reg_t'(`PAD_REG_RESET);
    end
    // rows 5 and 6 are out of range, rows 8 and 9 overwrite earlier pads
    stim_rows[0]  = make_row(8'd0, safe_domain_pkg::FUNC_PERIO, 6'h15, 1'b1);
    stim_rows[1]  = make_row(8'd1, safe_domain_pkg::FUNC_APBIO, 6'h2a, 1'b1);
    stim_rows[2]  = make_row(8'd2, safe_domain_pkg::FUNC_FPGAIO, 6'h3f, 1'b0);
    stim_rows[3]  = make_row(8'd15, safe_domain_pkg::FUNC_PERIO, 6'h01, 1'b1);
    stim_rows[4]  = make_row(8'd7, safe_domain_pkg::FUNC_OFF, 6'h30, 1'b1);
    stim_rows[5]  = make_row(8'd16, safe_domain_pkg::FUNC_PERIO, 6'h3f, 1'b1);
    stim_rows[6]  = make_row(8'd200, safe_domain_pkg::FUNC_APBIO, 6'h0c, 1'b1);
    stim_rows[7]  = make_row(8'd3, safe_domain_pkg::FUNC_APBIO, 6'h22, 1'b0);
    stim_rows[8]  = make_row(8'd0, safe_domain_pkg::FUNC_FPGAIO, 6'h08, 1'b1);
    stim_rows[9]  = make_row(8'd1, safe_domain_pkg::FUNC_OFF, 6'h00, 1'b1);
    stim_rows[10] = make_row(8'd9, safe_domain_pkg::FUNC_FPGAIO, 6'h11, 1'b0);
    stim_rows[11] = make_row(8'd15, safe_domain_pkg::FUNC_APBIO, 6'h3c, 1'b1);

    @(posedge rst_n);
    check_after_release();
    finish_test("reset release and slow clock");
    check_reset_state();
    finish_test("state after reset");
    for (int r = 0; r < int'(NUM_ROWS); r++) begin
      apply_row(stim_rows[r]);
      finish_test($sformatf("row %0d pad %0d", r, stim_rows[r].pad));
    end
    pulse_reset();
    check_after_release();
    finish_test("mid-run reset release and slow clock");
    check_reset_state();
    finish_test("state after mid-run reset");

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog against a run that stops making progress
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: verification/tb_clk_gen.sv
//**************************************************************************
// testbench clock and reset generator
// 4 ns reference clock, reset held low for the first 3 cycles and again
// for as long as a reset request is raised
//**************************************************************************

module tb_clk_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // power-on part of the reset, released once after 3 cycles
  logic por_n;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // the release lands 1 ns after the edge, like every other input
  initial begin
    por_n = 1'b0;
    repeat (3) @(posedge clk_o);
    #1;
    por_n = 1'b1;
  end

  assign rst_n_o = por_n & ~rst_req_i;

endmodule

// File: hw/safe_domain.sv
//**************************************************************************
// always-on pad domain
// stretched chip reset, slow always-on clock and per pad routing of the
// IO pads to the peripheral, bus-mapped and fabric signal groups
//**************************************************************************

`include "pad_reg_map.svh"

module safe_domain #(
  parameter int unsigned N_IO     = 16,
  parameter int unsigned SLOW_DIV = 8,
  parameter int unsigned RST_HOLD = 4
) (
  input  logic                                  ref_clk_i,
  input  logic                                  rst_n_i,
  output logic                                  rst_no,
  output logic                                  slow_clk_o,

  //************************************************************************
  // pad register access
  //************************************************************************

  input  logic                                  wr_stb_i,
  input  safe_domain_pkg::pad_cmd_t             wr_cmd_i,
  input  logic                                  rd_stb_i,
  input  logic [`PAD_ADDR_W-1:0]                rd_addr_i,
  output logic                                  rd_valid_o,
  output safe_domain_pkg::pad_reg_t             rd_data_o,

  //************************************************************************
  // pads
  //************************************************************************

  output safe_domain_pkg::pad_cfg_t [N_IO-1:0]  pad_cfg_o,
  output logic [N_IO-1:0]                       io_out_o,
  output logic [N_IO-1:0]                       io_oe_o,
  input  logic [N_IO-1:0]                       io_in_i,

  //************************************************************************
  // signal groups
  //************************************************************************

  // peripheral IO
  input  logic [N_IO-1:0]                       perio_out_i,
  input  logic [N_IO-1:0]                       perio_oe_i,
  output logic [N_IO-1:0]                       perio_in_o,

  // bus-mapped IO
  input  logic [N_IO-1:0]                       apbio_out_i,
  input  logic [N_IO-1:0]                       apbio_oe_i,
  output logic [N_IO-1:0]                       apbio_in_o,

  // fabric IO
  input  logic [N_IO-1:0]                       fpgaio_out_i,
  input  logic [N_IO-1:0]                       fpgaio_oe_i,
  output logic [N_IO-1:0]                       fpgaio_in_o
);

  // register contents feeding the pad multiplexer
  safe_domain_pkg::pad_reg_t [N_IO-1:0] s_pad_reg;

  //************************************************************************
  // pad register file
  //************************************************************************

  pad_regs #(
    .N_IO (N_IO)
  ) i_pad_regs (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .wr_stb_i   (wr_stb_i),
    .wr_cmd_i   (wr_cmd_i),
    .rd_stb_i   (rd_stb_i),
    .rd_addr_i  (rd_addr_i),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o),
    .pad_reg_o  (s_pad_reg)
  );

  //************************************************************************
  // pad multiplexer
  //************************************************************************

  pad_control #(
    .N_IO (N_IO)
  ) i_pad_control (
    .pad_reg_i    (s_pad_reg),
    .pad_cfg_o    (pad_cfg_o),
    .io_out_o     (io_out_o),
    .io_oe_o      (io_oe_o),
    .io_in_i      (io_in_i),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .perio_in_o   (perio_in_o),
    .apbio_out_i  (apbio_out_i),
    .apbio_oe_i   (apbio_oe_i),
    .apbio_in_o   (apbio_in_o),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .fpgaio_in_o  (fpgaio_in_o)
  );

  //************************************************************************
  // reset and slow clock
  //************************************************************************

  // chip reset for everything outside this domain
  rst_hold #(
    .RST_HOLD (RST_HOLD)
  ) i_rst_hold (
    .ref_clk_i (ref_clk_i),
    .rst_n_i   (rst_n_i),
    .rst_no    (rst_no)
  );

  // slow clock for the always-on logic
  slow_clk_div #(
    .SLOW_DIV (SLOW_DIV)
  ) i_slow_clk_div (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .slow_clk_o (slow_clk_o)
  );

endmodule

// File: hw/slow_clk_div.sv
//**************************************************************************
// slow clock divider
// derives the always-on slow clock from the reference clock, one slow
// period lasts SLOW_DIV reference cycles
//**************************************************************************

module slow_clk_div #(
  parameter int unsigned SLOW_DIV = 8
) (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic slow_clk_o
);

  // number of reference edges between two toggles
  localparam int unsigned Half = SLOW_DIV / 2;
  localparam int unsigned CntW = (Half > 1) ? $clog2(Half) : 1;

  logic [CntW-1:0] cnt_q;
  logic            clk_q;

  // an odd ratio cannot give a 50 percent duty cycle from one edge
  if ((SLOW_DIV % 2) != 0 || SLOW_DIV < 2) begin : g_bad_div
    $error("SLOW_DIV must be even and at least 2");
  end

  //************************************************************************
  // divider
  //************************************************************************

  // the counter wraps after Half edges and flips the output each time
  // it wraps, the output is a flop so the slow clock is glitch free
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else if (cnt_q == CntW'(Half - 1)) begin
      cnt_q <= '0;
      clk_q <= ~clk_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // slow clock starts low and leaves reset low
  assign slow_clk_o = clk_q;

endmodule

// File: hw/rst_hold.sv
//**************************************************************************
// reset stretcher
// keeps the chip reset low for RST_HOLD reference cycles after the
// external reset is released
//**************************************************************************

module rst_hold #(
  parameter int unsigned RST_HOLD = 4
) (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic rst_no
);

  // the counter has to hold the value RST_HOLD itself
  localparam int unsigned CntW = $clog2(RST_HOLD + 1);

  logic [CntW-1:0] cnt_q;
  logic            rst_q;

  // a zero hold would let the chip reset follow the pin with no margin
  if (RST_HOLD < 1) begin : g_bad_hold
    $error("RST_HOLD must be at least 1");
  end

  // the counter sits at zero during reset and counts one per edge once
  // the external reset is sampled high, so on the edge it reads
  // RST_HOLD the output goes high and the counter stops there
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      rst_q <= 1'b0;
    end else begin
      if (cnt_q != CntW'(RST_HOLD)) begin
        cnt_q <= cnt_q + 1'b1;
      end
      rst_q <= (cnt_q == CntW'(RST_HOLD));
    end
  end

  assign rst_no = rst_q;

  // the stretched reset can only be released out of a cycle in which
  // the external reset was already high
  a_no_early_release : assert property (
    @(posedge ref_clk_i)
    $rose(rst_no) |-> $past(rst_n_i)
  ) else $error("chip reset released while external reset was low");

endmodule

// File: hw/pad_control.sv
//**************************************************************************
// pad multiplexer
// connects every pad to one of the peripheral, bus-mapped or fabric
// signal groups, as chosen by the pad register, purely combinational
//**************************************************************************

module pad_control #(
  parameter int unsigned N_IO = 16
) (
  // register contents from the pad register file
  input  safe_domain_pkg::pad_reg_t [N_IO-1:0]  pad_reg_i,
  output safe_domain_pkg::pad_cfg_t [N_IO-1:0]  pad_cfg_o,

  // pad side
  output logic [N_IO-1:0]                       io_out_o,
  output logic [N_IO-1:0]                       io_oe_o,
  input  logic [N_IO-1:0]                       io_in_i,

  // peripheral IO group
  input  logic [N_IO-1:0]                       perio_out_i,
  input  logic [N_IO-1:0]                       perio_oe_i,
  output logic [N_IO-1:0]                       perio_in_o,

  // bus-mapped IO group
  input  logic [N_IO-1:0]                       apbio_out_i,
  input  logic [N_IO-1:0]                       apbio_oe_i,
  output logic [N_IO-1:0]                       apbio_in_o,

  // fabric IO group
  input  logic [N_IO-1:0]                       fpgaio_out_i,
  input  logic [N_IO-1:0]                       fpgaio_oe_i,
  output logic [N_IO-1:0]                       fpgaio_in_o
);

  //************************************************************************
  // per pad routing
  //************************************************************************

  // each pad starts out undriven with its input going nowhere, then
  // the selected group gets the out/oe pair and the input bit
  always_comb begin
    for (int i = 0; i < N_IO; i++) begin
      pad_cfg_o[i]   = pad_reg_i[i].cfg;
      io_out_o[i]    = 1'b0;
      io_oe_o[i]     = 1'b0;
      perio_in_o[i]  = 1'b0;
      apbio_in_o[i]  = 1'b0;
      fpgaio_in_o[i] = 1'b0;
      unique case (pad_reg_i[i].func)
        safe_domain_pkg::FUNC_PERIO: begin
          io_out_o[i]   = perio_out_i[i];
          io_oe_o[i]    = perio_oe_i[i];
          perio_in_o[i] = io_in_i[i];
        end
        safe_domain_pkg::FUNC_APBIO: begin
          io_out_o[i]   = apbio_out_i[i];
          io_oe_o[i]    = apbio_oe_i[i];
          apbio_in_o[i] = io_in_i[i];
        end
        safe_domain_pkg::FUNC_FPGAIO: begin
          io_out_o[i]    = fpgaio_out_i[i];
          io_oe_o[i]     = fpgaio_oe_i[i];
          fpgaio_in_o[i] = io_in_i[i];
        end
        safe_domain_pkg::FUNC_OFF: begin
          // defaults above already leave the pad switched off
        end
      endcase
    end
  end

  // a pad input may reach at most one group, and any group input bit
  // that is set must come from a pad input that is set
  always_comb begin
    for (int i = 0; i < N_IO; i++) begin
      a_one_group : assert ($onehot0({perio_in_o[i], apbio_in_o[i], fpgaio_in_o[i]})
                            && (!(perio_in_o[i] || apbio_in_o[i] || fpgaio_in_o[i])
                                || io_in_i[i]))
        else $error("pad %0d input routed to more than one group", i);
    end
  end

endmodule

// File: hw/pad_regs.sv
//**************************************************************************
// pad register file
// holds function select and configuration for every pad, written and
// read over single-cycle strobes, read data comes one cycle later
//**************************************************************************

`include "pad_reg_map.svh"

module pad_regs #(
  parameter int unsigned N_IO = 16
) (
  input  logic                                  ref_clk_i,
  input  logic                                  rst_n_i,

  // write port
  input  logic                                  wr_stb_i,
  input  safe_domain_pkg::pad_cmd_t             wr_cmd_i,

  // read port
  input  logic                                  rd_stb_i,
  input  logic [`PAD_ADDR_W-1:0]                rd_addr_i,
  output logic                                  rd_valid_o,
  output safe_domain_pkg::pad_reg_t             rd_data_o,

  // current register contents towards pad control
  output safe_domain_pkg::pad_reg_t [N_IO-1:0]  pad_reg_o
);

  // register array, one entry per pad
  safe_domain_pkg::pad_reg_t [N_IO-1:0] regs_q;

  // read mux output and the registered read result
  safe_domain_pkg::pad_reg_t            rd_data_d;
  safe_domain_pkg::pad_reg_t            rd_data_q;
  logic                                 rd_valid_q;

  //************************************************************************
  // register array
  //************************************************************************

  // every pad comes out of reset switched off
  // a write only lands if its address matches one of the pads, so
  // addresses of N_IO and above fall through without effect
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < N_IO; i++) begin
        regs_q[i] <= safe_domain_pkg::pad_reg_t'(`PAD_REG_RESET);
      end
    end else if (wr_stb_i) begin
      for (int i = 0; i < N_IO; i++) begin
        if (int'(wr_cmd_i.addr) == i) begin
          regs_q[i] <= wr_cmd_i.data;
        end
      end
    end
  end

  //************************************************************************
  // read path
  //************************************************************************

  // the mux looks at the stored values, so a write in the same cycle
  // is not visible yet and the read gets the old contents
  // out of range addresses keep the reset value
  always_comb begin
    rd_data_d = safe_domain_pkg::pad_reg_t'(`PAD_REG_RESET);
    for (int i = 0; i < N_IO; i++) begin
      if (int'(rd_addr_i) == i) begin
        rd_data_d = regs_q[i];
      end
    end
  end

  // valid goes high for one cycle after each read strobe
  always_ff @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_stb_i;
    end
  end

  // read data is captured on the read strobe and held until the next one
  always_ff @(posedge ref_clk_i) begin
    if (rd_stb_i) begin
      rd_data_q <= rd_data_d;
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = rd_data_q;
  assign pad_reg_o  = regs_q;

  // every read strobe gets exactly one valid, one cycle later, and a
  // valid never shows up without a strobe the cycle before
  a_rd_latency : assert property (
    @(posedge ref_clk_i) disable iff (!rst_n_i)
    1'b1 |=> (rd_valid_o == $past(rd_stb_i))
  ) else $error("read valid does not follow read strobe by one cycle");

endmodule

// File: hw/safe_domain_pkg.sv
//**************************************************************************
// shared types of the always-on pad domain
// pad function select, pad configuration, pad register and the
// command word used to write the pad register file
//**************************************************************************

`include "pad_reg_map.svh"

package safe_domain_pkg;

  //************************************************************************
  // pad function select
  //************************************************************************

  // selects which signal group drives a pad and receives its input
  // FUNC_OFF leaves the pad undriven and drops its input
  typedef enum logic [1:0] {
    FUNC_PERIO  = 2'd0,
    FUNC_APBIO  = 2'd1,
    FUNC_FPGAIO = 2'd2,
    FUNC_OFF    = 2'd3
  } pad_func_e;

  //************************************************************************
  // pad electrical configuration
  //************************************************************************

  // passed to the pad ring as is, nothing in this domain decodes it
  typedef struct packed {
    // enable the pull resistor
    logic       pull_en;
    // pull direction, set for pull up and clear for pull down
    logic       pull_up;
    // drive strength code
    logic [1:0] drive;
    // schmitt trigger on the input buffer
    logic       schmitt;
    // fast slew rate on the output buffer
    logic       slew_fast;
  } pad_cfg_t;

  //************************************************************************
  // pad register and register command
  //************************************************************************

  // one pad register, cfg in the upper bits and func in the low bits
  typedef struct packed {
    pad_cfg_t  cfg;
    pad_func_e func;
  } pad_reg_t;

  // write command, the address is the pad index
  typedef struct packed {
    logic [`PAD_ADDR_W-1:0] addr;
    pad_reg_t               data;
  } pad_cmd_t;

endpackage

// File: include/pad_reg_map.svh
//**************************************************************************
// register map of the pad register file in the always-on domain
// one 8-bit register per pad, the address is the pad index
//**************************************************************************

`ifndef PAD_REG_MAP_SVH
`define PAD_REG_MAP_SVH

// width of the pad address on the read and write ports
`define PAD_ADDR_W 8

// width of one pad register
`define PAD_REG_W 8

// function select field, low bits of the register
`define PAD_FUNC_LSB 0
`define PAD_FUNC_W 2

// pad configuration field, sits above the function select
`define PAD_CFG_LSB 2
`define PAD_CFG_W 6

// reset value: pad switched off, all configuration bits cleared
`define PAD_REG_RESET 8'h03

`endif
